// File: Makefile
VERILATOR ?= verilator
TOP       ?= datapath_tb
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
FILELIST  ?= datapath.f
PASS_MSG  ?= STATUS: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: datapath.f
+incdir+include
rtl/lc3b_types.sv
rtl/ir.sv
rtl/control_rom.sv
rtl/regfile.sv
rtl/alu.sv
rtl/datapath.sv
tests/datapath_tb.sv

// File: include/lc3b_macros.svh
`ifndef LC3B_MACROS_SVH
`define LC3B_MACROS_SVH

// address of the first fetch after reset
`define LC3B_RESET_PC 16'h0000

// general purpose registers R0..R7
`define LC3B_NUM_REGS 8

`endif

// File: rtl/alu.sv
`default_nettype none

module alu
(
    input  lc3b_types::lc3b_aluop aluop,
    input  lc3b_types::lc3b_word  a,
    input  lc3b_types::lc3b_word  b,
    output lc3b_types::lc3b_word  f
);

    always_comb
    begin
        case (aluop)
            lc3b_types::alu_add: f = a + b;
            lc3b_types::alu_and: f = a & b;
            lc3b_types::alu_not: f = ~a;
            default:             f = b;     // pass
        endcase
    end

endmodule : alu

`default_nettype wire

// File: rtl/control_rom.sv
`default_nettype none

module control_rom
(
    input  lc3b_types::lc3b_opcode       opcode,
    input  logic                         imm_enable,
    input  logic                         is_nop,
    output lc3b_types::lc3b_control_word ctrl
);

    always_comb
    begin
        ctrl = '0;                      // all-inactive word
        if (!is_nop)
        begin
            case (opcode)
                lc3b_types::op_add, lc3b_types::op_and:
                begin
                    ctrl.aluop        = (opcode == lc3b_types::op_add) ?
                                        lc3b_types::alu_add : lc3b_types::alu_and;
                    ctrl.alumux_sel   = imm_enable;
                    ctrl.load_regfile = 1'b1;
                    ctrl.load_cc      = 1'b1;
                end
                lc3b_types::op_not:
                begin
                    ctrl.aluop        = lc3b_types::alu_not;
                    ctrl.load_regfile = 1'b1;
                    ctrl.load_cc      = 1'b1;
                end
                lc3b_types::op_lea:
                begin
                    ctrl.regfilemux_sel = 2'b10;  // pc + offset9
                    ctrl.load_regfile   = 1'b1;
                    ctrl.load_cc        = 1'b1;
                end
                lc3b_types::op_ldr:
                begin
                    ctrl.marmux_sel      = 1'b1;
                    ctrl.mem_read        = 1'b1;
                    ctrl.mem_byte_enable = 2'b11;
                    ctrl.regfilemux_sel  = 2'b01;
                    ctrl.load_regfile    = 1'b1;
                    ctrl.load_cc         = 1'b1;
                end
                lc3b_types::op_str:
                begin
                    ctrl.marmux_sel      = 1'b1;
                    ctrl.mem_write       = 1'b1;
                    ctrl.mem_byte_enable = 2'b11;
                    ctrl.storemux_sel    = 1'b1;
                end
                lc3b_types::op_stb:
                begin
                    ctrl.marmux_sel        = 1'b1;
                    ctrl.mem_write         = 1'b1;
                    ctrl.mem_byte_enable   = 2'b01;  // moved to high lane on odd address
                    ctrl.stb_filter_enable = 1'b1;
                    ctrl.storemux_sel      = 1'b1;
                end
                lc3b_types::op_br:
                    ctrl.br_enable = 1'b1;
                default:
                    ctrl = '0;          // unsupported opcodes run as nops
            endcase
        end
    end

endmodule : control_rom

`default_nettype wire

// File: rtl/datapath.sv
`default_nettype none

`include "lc3b_macros.svh"

module datapath
(
    input  logic                      clk,
    input  logic                      rst_n,
    output lc3b_types::lc3b_word      instr_address,
    output logic                      instr_read,
    input  lc3b_types::lc3b_word      instr_rdata,
    input  logic                      i_mem_resp,
    output lc3b_types::lc3b_word      mem_address,
    output lc3b_types::lc3b_word      mem_wdata,
    output lc3b_types::lc3b_mem_wmask mem_byte_enable,
    output logic                      mem_read,
    output logic                      mem_write,
    input  lc3b_types::lc3b_word      mem_rdata,
    input  logic                      d_mem_resp
);

    logic global_load;
    logic is_nop;
    logic branch_taken;

    lc3b_types::lc3b_opcode  opcode;
    lc3b_types::lc3b_reg     dest, src1, src2, src_b;
    logic                    imm_enable;
    lc3b_types::lc3b_offset5 offset5;
    lc3b_types::lc3b_offset6 offset6;
    lc3b_types::lc3b_offset9 offset9;
    lc3b_types::lc3b_word    ir_word, sr1_out, sr2_out, offset_dec;

    lc3b_types::lc3b_control_word ctrl, ctrl_ex, ctrl_mem, ctrl_wb;

    lc3b_types::lc3b_word pc_plus2, pc_dec, pc_ex;
    lc3b_types::lc3b_word sr1_ex, sr2_ex, imm_ex, off_ex;
    lc3b_types::lc3b_word alumux_out, alu_out, offset_sum, offs_mem;
    lc3b_types::lc3b_word res_wb, mdr_wb, offs_wb, regfilemux_out;
    lc3b_types::lc3b_reg  dest_ex, dest_mem, dest_wb;
    lc3b_types::lc3b_nzp  cc, gencc;

    // stall everything until both memories have answered
    assign global_load = i_mem_resp & (d_mem_resp | ~(ctrl_mem.mem_read | ctrl_mem.mem_write));
    assign instr_read  = 1'b1;
    assign pc_plus2    = instr_address + 16'd2;
    assign is_nop      = (ir_word == '0);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            instr_address <= `LC3B_RESET_PC;
        else if (global_load)
            instr_address <= branch_taken ? offs_mem : pc_plus2;
    end

    ir ir_inst
    (
        .clk(clk), .rst_n(rst_n), .load(global_load), .in(instr_rdata),
        .opcode(opcode), .dest(dest), .src1(src1), .src2(src2),
        .imm_enable(imm_enable), .offset5(offset5), .offset6(offset6),
        .offset9(offset9), .out(ir_word)
    );

    control_rom control_rom_inst
    (
        .opcode(opcode), .imm_enable(imm_enable), .is_nop(is_nop), .ctrl(ctrl)
    );

    assign src_b = ctrl.storemux_sel ? dest : src2;     // stores read SR from [11:9]

    regfile regfile_inst
    (
        .clk(clk), .rst_n(rst_n), .load(ctrl_wb.load_regfile & global_load),
        .in(regfilemux_out), .src_a(src1), .src_b(src_b), .dest(dest_wb),
        .reg_a(sr1_out), .reg_b(sr2_out)
    );

    // byte offset for STB, word offsets shifted
    always_comb
    begin
        if (!ctrl.marmux_sel)
            offset_dec = {{6{offset9[8]}}, offset9, 1'b0};
        else if (ctrl.stb_filter_enable)
            offset_dec = {{10{offset6[5]}}, offset6};
        else
            offset_dec = {{9{offset6[5]}}, offset6, 1'b0};
    end

    // control copies reset to the nop word
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ctrl_ex  <= '0;
            ctrl_mem <= '0;
            ctrl_wb  <= '0;
        end
        else if (global_load)
        begin
            ctrl_ex  <= ctrl;
            ctrl_mem <= ctrl_ex;
            ctrl_wb  <= ctrl_mem;
        end
    end

    always_ff @(posedge clk)
    begin
        if (global_load)
        begin
            pc_dec   <= pc_plus2;
            pc_ex    <= pc_dec;
            sr1_ex   <= sr1_out;
            sr2_ex   <= sr2_out;
            imm_ex   <= {{11{offset5[4]}}, offset5};
            off_ex   <= offset_dec;
            dest_ex  <= dest;
            dest_mem <= dest_ex;
            dest_wb  <= dest_mem;
        end
    end

    assign alumux_out = ctrl_ex.alumux_sel ? imm_ex : sr2_ex;

    alu alu_inst
    (
        .aluop(ctrl_ex.aluop), .a(sr1_ex), .b(alumux_out), .f(alu_out)
    );

    // base register for memory ops, pc for LEA and BR
    assign offset_sum = (ctrl_ex.marmux_sel ? sr1_ex : pc_ex) + off_ex;

    always_ff @(posedge clk)
    begin
        if (global_load)
        begin
            mem_address <= ctrl_ex.marmux_sel ? offset_sum : alu_out;
            mem_wdata   <= ctrl_ex.stb_filter_enable ? {sr2_ex[7:0], sr2_ex[7:0]} : sr2_ex;
            offs_mem    <= offset_sum;  // branch target
            res_wb      <= mem_address;
            mdr_wb      <= mem_rdata;
            offs_wb     <= offs_mem;
        end
    end

    assign mem_read  = ctrl_mem.mem_read;
    assign mem_write = ctrl_mem.mem_write;
    assign mem_byte_enable = (ctrl_mem.stb_filter_enable && mem_address[0]) ?
                             2'b10 : ctrl_mem.mem_byte_enable;

    assign branch_taken = ctrl_mem.br_enable & (|(dest_mem & cc));

    always_comb
    begin
        case (ctrl_wb.regfilemux_sel)
            2'b01:   regfilemux_out = mdr_wb;
            2'b10:   regfilemux_out = offs_wb;
            default: regfilemux_out = res_wb;
        endcase
        if (regfilemux_out[15])
            gencc = 3'b100;
        else if (regfilemux_out == '0)
            gencc = 3'b010;
        else
            gencc = 3'b001;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            cc <= 3'b010;               // z after reset
        else if (global_load && ctrl_wb.load_cc)
            cc <= gencc;
    end

    rw_exclusive_a : assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read && mem_write));

    // data request held with its address and data until the response
    req_hold_a : assert property (@(posedge clk) disable iff (!rst_n)
        ((mem_read || mem_write) && !d_mem_resp) |=>
            $stable({mem_read, mem_write, mem_address, mem_wdata}));

endmodule : datapath

`default_nettype wire

// File: rtl/ir.sv
`default_nettype none

module ir
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    load,
    input  lc3b_types::lc3b_word    in,
    output lc3b_types::lc3b_opcode  opcode,
    output lc3b_types::lc3b_reg     dest,
    output lc3b_types::lc3b_reg     src1,
    output lc3b_types::lc3b_reg     src2,
    output logic                    imm_enable,
    output lc3b_types::lc3b_offset5 offset5,
    output lc3b_types::lc3b_offset6 offset6,
    output lc3b_types::lc3b_offset9 offset9,
    output lc3b_types::lc3b_word    out
);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            out <= '0;                  // zero word is a nop
        else if (load)
            out <= in;
    end

    always_comb
    begin
        opcode     = lc3b_types::lc3b_opcode'(out[15:12]);
        dest       = out[11:9];         // also nzp bits of BR
        src1       = out[8:6];          // base register for LDR/STR/STB
        src2       = out[2:0];
        imm_enable = out[5];
        offset5    = out[4:0];
        offset6    = out[5:0];
        offset9    = out[8:0];
    end

endmodule : ir

`default_nettype wire

// File: rtl/lc3b_types.sv
`default_nettype none

package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [7:0]  lc3b_byte;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [2:0]  lc3b_nzp;        // n, z, p
    typedef logic [1:0]  lc3b_mem_wmask;  // [1] high byte, [0] low byte
    typedef logic [4:0]  lc3b_offset5;
    typedef logic [5:0]  lc3b_offset6;
    typedef logic [8:0]  lc3b_offset9;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add  = 2'b00,
        alu_and  = 2'b01,
        alu_not  = 2'b10,
        alu_pass = 2'b11
    } lc3b_aluop;

    typedef struct packed {
        lc3b_aluop     aluop;
        logic          alumux_sel;        // 0 register, 1 imm5
        logic          marmux_sel;        // 0 alu result, 1 offset adder
        logic [1:0]    regfilemux_sel;    // 00 alu, 01 mem data, 10 offset adder
        logic          load_regfile;
        logic          load_cc;
        logic          mem_read;
        logic          mem_write;
        lc3b_mem_wmask mem_byte_enable;
        logic          stb_filter_enable;
        logic          br_enable;
        logic          storemux_sel;      // 0 src2, 1 dest field
    } lc3b_control_word;

endpackage : lc3b_types

`default_nettype wire

// File: rtl/regfile.sv
`default_nettype none

`include "lc3b_macros.svh"

module regfile
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load,
    input  lc3b_types::lc3b_word in,
    input  lc3b_types::lc3b_reg  src_a,
    input  lc3b_types::lc3b_reg  src_b,
    input  lc3b_types::lc3b_reg  dest,
    output lc3b_types::lc3b_word reg_a,
    output lc3b_types::lc3b_word reg_b
);

    lc3b_types::lc3b_word data [`LC3B_NUM_REGS];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `LC3B_NUM_REGS; i++)
                data[i] <= '0;
        end
        else if (load)
            data[dest] <= in;
    end

    // no write-through, reads see the old value
    assign reg_a = data[src_a];
    assign reg_b = data[src_b];

    dest_known_a : assert property (@(posedge clk) disable iff (!rst_n)
        load |-> !$isunknown(dest));

endmodule : regfile

`default_nettype wire

// File: tests/datapath_tb.sv
`default_nettype none

`include "lc3b_macros.svh"

module datapath_tb;

    localparam int NUM_STORES = 13;
    localparam int TIMEOUT    = 400;                        // cycles per wait
    localparam lc3b_types::lc3b_word HALT_ADDR = 16'h0036;  // BR-to-self at word 27

    logic clk;
    logic rst_n;
    logic instr_read, mem_read, mem_write;
    logic i_mem_resp = 1'b0;
    logic d_mem_resp = 1'b0;
    lc3b_types::lc3b_word instr_rdata = '0;
    lc3b_types::lc3b_word mem_rdata   = '0;
    lc3b_types::lc3b_word instr_address, mem_address, mem_wdata;
    lc3b_types::lc3b_mem_wmask mem_byte_enable;

    lc3b_types::lc3b_word imem [64];
    lc3b_types::lc3b_word dmem [64];
    int unsigned i_delay, d_delay;
    int unsigned halt_fetches = 0;
    logic [33:0] store_q [$];               // {address, data, mask}
    logic [33:0] expected [NUM_STORES];

    datapath datapath_inst
    (
        .clk(clk), .rst_n(rst_n),
        .instr_address(instr_address), .instr_read(instr_read),
        .instr_rdata(instr_rdata), .i_mem_resp(i_mem_resp),
        .mem_address(mem_address), .mem_wdata(mem_wdata),
        .mem_byte_enable(mem_byte_enable), .mem_read(mem_read), .mem_write(mem_write),
        .mem_rdata(mem_rdata), .d_mem_resp(d_mem_resp)
    );

    function automatic lc3b_types::lc3b_word fill_word(input int i);
        return 16'h3C5A ^ 16'(i * 16'h0B1D);
    endfunction

    task automatic check(input logic [33:0] actual, input logic [33:0] exp, input string what);
        if (actual !== exp)
        begin
            $display("FAILED at time %0t: %s, got %h, expected %h", $time, what, actual, exp);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic give_up(input string what);
        $display("Timeout at time %0t: %s", $time, what);
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    endtask

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial
    begin
        for (int i = 0; i < 64; i++)
        begin
            imem[i] = '0;                       // nop
            dmem[i] = fill_word(i);
        end
        imem[0]  = 16'h1227;    // ADD R1, R0, #7
        imem[1]  = 16'h143D;    // ADD R2, R0, #-3
        imem[2]  = 16'h162C;    // ADD R3, R0, #12
        imem[3]  = 16'h6814;    // LDR R4, R0, #20
        imem[4]  = 16'h5A65;    // AND R5, R1, #5
        imem[5]  = 16'h9CBF;    // NOT R6, R2
        imem[6]  = 16'h1E43;    // ADD R7, R1, R3
        imem[7]  = 16'h781E;    // STR R4, R0, #30
        imem[8]  = 16'h7A18;    // STR R5, R0, #24
        imem[9]  = 16'h7C19;    // STR R6, R0, #25
        imem[10] = 16'h7E1A;    // STR R7, R0, #26
        imem[11] = 16'h5A83;    // AND R5, R2, R3
        imem[12] = 16'hEC05;    // LEA R6, #5
        imem[13] = 16'h741C;    // STR R2, R0, #28
        imem[14] = 16'h320A;    // STB R1, R0, #10
        imem[15] = 16'h7A1D;    // STR R5, R0, #29
        imem[16] = 16'h7C1F;    // STR R6, R0, #31
        imem[17] = 16'h340B;    // STB R2, R0, #11
        imem[18] = 16'h5620;    // AND R3, R0, #0
        imem[20] = 16'h0804;    // BRn to word 25, not taken
        imem[21] = 16'h0404;    // BRz to word 26, taken
        imem[22] = 16'h7201;    // STR R1, R0, #1
        imem[23] = 16'h7E02;    // STR R7, R0, #2
        imem[24] = 16'h7403;    // STR R2, R0, #3
        imem[25] = 16'h7204;    // STR R1, R0, #4 skipped
        imem[26] = 16'h7C06;    // STR R6, R0, #6
        imem[27] = 16'h0FFF;    // BRnzp to self
        expected[0]  = {16'd60, fill_word(20), 2'b11};  // loaded word copied
        expected[1]  = {16'd48, 16'h0005, 2'b11};
        expected[2]  = {16'd50, 16'h0002, 2'b11};
        expected[3]  = {16'd52, 16'h0013, 2'b11};
        expected[4]  = {16'd56, 16'hFFFD, 2'b11};
        expected[5]  = {16'd10, 16'h0707, 2'b01};       // even byte
        expected[6]  = {16'd58, 16'h000C, 2'b11};
        expected[7]  = {16'd62, 16'h0024, 2'b11};       // LEA at word 12
        expected[8]  = {16'd11, 16'hFDFD, 2'b10};       // odd byte
        expected[9]  = {16'd2,  16'h0007, 2'b11};       // delay slots
        expected[10] = {16'd4,  16'h0013, 2'b11};
        expected[11] = {16'd6,  16'hFFFD, 2'b11};
        expected[12] = {16'd12, 16'h0024, 2'b11};       // branch target
    end

    // both memories answer on the falling edge after 0 to 3 cycles
    always @(negedge clk)
    begin
        i_mem_resp  = 1'b0;
        d_mem_resp  = 1'b0;
        instr_rdata = imem[instr_address[6:1]];
        if (instr_read)
        begin
            if (i_delay == 0)
            begin
                i_mem_resp = 1'b1;
                i_delay    = $urandom % 4;
            end
            else
                i_delay--;
        end
        if (mem_read || mem_write)
        begin
            mem_rdata = dmem[mem_address[6:1]];
            if (d_delay == 0)
            begin
                d_mem_resp = 1'b1;
                d_delay    = $urandom % 4;
                if (mem_write && mem_byte_enable[0])
                    dmem[mem_address[6:1]][7:0] = mem_wdata[7:0];
                if (mem_write && mem_byte_enable[1])
                    dmem[mem_address[6:1]][15:8] = mem_wdata[15:8];
            end
            else
                d_delay--;
        end
        // the pipeline only moves when both sides have answered
        if (mem_write && d_mem_resp && i_mem_resp)
            store_q.push_back({mem_address, mem_wdata, mem_byte_enable});
        if (i_mem_resp && (d_mem_resp || !(mem_read || mem_write)) && instr_address == HALT_ADDR)
            halt_fetches++;
    end

    initial
    begin
        int wait_cycles;
        rst_n = 1'b0;
        void'($urandom(9897));
        i_delay = $urandom % 4;
        d_delay = $urandom % 4;
        repeat (10) @(negedge clk);
        check({15'b0, instr_address, instr_read, mem_read, mem_write},
              {15'b0, `LC3B_RESET_PC, 3'b100}, "state after reset");
        rst_n = 1'b1;

        for (int n = 0; n < NUM_STORES; n++)
        begin
            wait_cycles = 0;
            while (store_q.size() == 0)
            begin
                @(posedge clk);
                wait_cycles++;
                if (wait_cycles > TIMEOUT)
                    give_up($sformatf("store %0d of %0d never arrived", n + 1, NUM_STORES));
            end
            check(store_q.pop_front(), expected[n], $sformatf("store %0d", n + 1));
        end

        wait_cycles = 0;
        while (halt_fetches < 3)
        begin
            @(posedge clk);
            wait_cycles++;
            if (wait_cycles > TIMEOUT)
                give_up("the program never reached its halt loop");
        end
        check(34'(store_q.size()), 34'd0, "stores after the last expected one");
        $display("STATUS: PASS");
        $finish;
    end

endmodule : datapath_tb

`default_nettype wire
